// ==== logic/dphy_rx_pkg.sv ====
package dphy_rx_pkg;

  // D-PHY leader byte that opens every high-speed burst
  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  localparam logic [7:0] LONG_PKT_MIN_ID = 8'h10; // Data IDs from here up carry a payload

  // One byte from a lane receiver after bit alignment
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } lane_byte_t;

  // Byte 0 on the wire is data_id, bytes 1 and 2 the word count LSB first, byte 3 the ECC
  typedef struct packed {
    logic [7:0]  data_id;
    logic [15:0] word_count;
    logic [7:0]  ecc;
  } pkt_hdr_t;

  localparam logic [11:0] ADDR_CTRL      = 12'h000; // Lane enables
  localparam logic [11:0] ADDR_STATUS    = 12'h004; // Lane lock bits
  localparam logic [11:0] ADDR_PKT_COUNT = 12'h008;
  localparam logic [11:0] ADDR_LAST_HDR  = 12'h00C;
  localparam logic [11:0] ADDR_ERR_COUNT = 12'h010; // Truncated packets

endpackage

// ==== logic/dphy_hs_lane_rx.sv ====
`timescale 1ns/1ps

module dphy_hs_lane_rx (
  input  logic                    byte_clk_i,
  input  logic                    arst_n_i,
  input  logic                    enable_i,
  input  logic [7:0]              raw_i,
  output dphy_rx_pkg::lane_byte_t byte_o,
  output logic                    lock_o
);

  import dphy_rx_pkg::*;

  logic [7:0]  raw_q;
  logic [7:0]  raw_qq;
  logic [15:0] window;
  logic        hit;
  logic [2:0]  hit_offset;
  logic        synced_q;
  logic [2:0]  offset_q;
  logic        valid_q;
  logic [7:0]  data_q;

  // Older word in the low half, so window bit 0 is the earliest received bit.
  // Offset k takes the byte that ends k bits before the end of the newer word
  assign window = {raw_q, raw_qq};

  always_comb
  begin
    hit        = 1'b0;
    hit_offset = '0;
    for (int k = 7; k >= 0; k--) // Lowest matching offset wins
    begin
      if (window[15 - k -: 8] == SYNC_BYTE)
      begin
        hit        = 1'b1;
        hit_offset = 3'(k);
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    raw_q  <= raw_i;
    raw_qq <= raw_q;
  end

  always_ff @(posedge byte_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      synced_q <= 1'b0;
      offset_q <= '0;
      valid_q  <= 1'b0;
    end
    else if (!enable_i)
    begin
      synced_q <= 1'b0; // End of the burst, hunt again next time
      valid_q  <= 1'b0;
    end
    else if (!synced_q)
    begin
      synced_q <= hit;
      offset_q <= hit_offset;
    end
    else
      valid_q <= 1'b1; // First byte after the leader
  end

  always_ff @(posedge byte_clk_i)
  begin
    data_q <= window[15 - offset_q -: 8];
  end

  assign byte_o = '{valid: valid_q, data: data_q};
  assign lock_o = valid_q; // Lock and valid share one timing

endmodule

// ==== logic/dphy_lane_merge.sv ====
`timescale 1ns/1ps

module dphy_lane_merge #(
  parameter int NUM_LANES = 2
)(
  input  logic                                    byte_clk_i,
  input  logic                                    arst_n_i,
  input  dphy_rx_pkg::lane_byte_t [NUM_LANES-1:0] lanes_i,
  input  logic [NUM_LANES-1:0]                    lane_en_i,
  output logic                                    valid_o,
  output logic [NUM_LANES-1:0][7:0]               data_o
);

  logic [NUM_LANES-1:0] lane_valid;
  logic                 word_ready;

  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
      lane_valid[k] = lanes_i[k].valid;
  end

  // A word exists only once every enabled lane has delivered its byte
  assign word_ready = (|lane_en_i) && (&(lane_valid | ~lane_en_i));

  always_ff @(posedge byte_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_o <= 1'b0;
    else
      valid_o <= word_ready;
  end

  // Round robin distribution puts byte k of each word on lane k
  always_ff @(posedge byte_clk_i)
  begin
    for (int k = 0; k < NUM_LANES; k++)
      data_o[k] <= lane_en_i[k] ? lanes_i[k].data : 8'h00;
  end

endmodule

// ==== logic/csi_pkt_parser.sv ====
`timescale 1ns/1ps

module csi_pkt_parser #(
  parameter int NUM_LANES = 2
)(
  input  logic                      byte_clk_i,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  logic [NUM_LANES-1:0][7:0] data_i,
  output logic                      hdr_valid_o,
  output dphy_rx_pkg::pkt_hdr_t     hdr_o,
  output logic                      pay_valid_o,
  output logic [NUM_LANES-1:0][7:0] pay_data_o,
  output logic [NUM_LANES-1:0]      pay_strb_o,
  output logic                      trunc_o
);

  import dphy_rx_pkg::*;

  localparam int HDR_BYTES = 4;
  localparam int CRC_BYTES = 2;

  logic [17:0]          cnt_q; // Packet bytes consumed before the current word
  logic [17:0]          cnt_next;
  logic                 done_q;
  logic [3:0][7:0]      hdr_bytes_q;
  logic [3:0][7:0]      hdr_bytes_d;
  pkt_hdr_t             hdr_d;
  logic                 hdr_last;
  logic                 is_long;
  logic [17:0]          pay_end;
  logic [17:0]          pkt_end;
  logic [NUM_LANES-1:0] strb;

  assign cnt_next = cnt_q + 18'(NUM_LANES);
  assign hdr_last = (cnt_q < 18'(HDR_BYTES)) && (cnt_next >= 18'(HDR_BYTES));
  assign is_long  = (hdr_o.data_id >= LONG_PKT_MIN_ID);
  assign pay_end  = 18'(HDR_BYTES) + 18'(hdr_o.word_count);
  assign pkt_end  = pay_end + 18'(CRC_BYTES);

  always_comb
  begin
    hdr_bytes_d = hdr_bytes_q;
    for (int k = 0; k < NUM_LANES; k++)
    begin
      if (cnt_q + 18'(k) < 18'(HDR_BYTES))
        hdr_bytes_d[cnt_q[1:0] + 2'(k)] = data_i[k];
      // Bytes past the payload end are CRC and get no strobe
      strb[k] = !done_q && is_long && (cnt_q >= 18'(HDR_BYTES)) &&
                (cnt_q + 18'(k) < pay_end);
    end
  end

  assign hdr_d = '{data_id:    hdr_bytes_d[0],
                   word_count: {hdr_bytes_d[2], hdr_bytes_d[1]},
                   ecc:        hdr_bytes_d[3]};

  always_ff @(posedge byte_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt_q       <= '0;
      done_q      <= 1'b0;
      hdr_o       <= '0;
      hdr_valid_o <= 1'b0;
      pay_valid_o <= 1'b0;
      pay_strb_o  <= '0;
      trunc_o     <= 1'b0;
    end
    else
    begin
      hdr_valid_o <= 1'b0;
      trunc_o     <= 1'b0;
      pay_valid_o <= valid_i && (|strb);
      pay_strb_o  <= valid_i ? strb : '0;
      if (!valid_i)
      begin
        trunc_o <= (cnt_q != '0) && !done_q; // Burst ended inside a packet
        cnt_q   <= '0;
        done_q  <= 1'b0;
      end
      else if (!done_q)
      begin
        cnt_q <= cnt_next;
        if (hdr_last)
        begin
          hdr_valid_o <= 1'b1;
          hdr_o       <= hdr_d;
          done_q      <= (hdr_d.data_id < LONG_PKT_MIN_ID); // Short packet is complete
        end
        else if ((cnt_q >= 18'(HDR_BYTES)) && (cnt_next >= pkt_end))
          done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (valid_i)
      hdr_bytes_q <= hdr_bytes_d;
    pay_data_o <= data_i;
  end

endmodule

// ==== logic/dphy_rx_regs.sv ====
`timescale 1ns/1ps

module dphy_rx_regs #(
  parameter int NUM_LANES = 2
)(
  input  logic                  byte_clk_i,
  input  logic                  arst_n_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [11:0]           paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  logic [NUM_LANES-1:0]  lock_i,
  input  logic                  hdr_valid_i,
  input  dphy_rx_pkg::pkt_hdr_t hdr_i,
  input  logic                  trunc_i,
  output logic [NUM_LANES-1:0]  lane_en_o
);

  import dphy_rx_pkg::*;

  logic [NUM_LANES-1:0] ctrl_q;
  logic [31:0]          pkt_count_q;
  logic [31:0]          err_count_q;
  pkt_hdr_t             last_hdr_q;
  logic                 access;
  logic                 mapped;

  assign access    = psel_i && penable_i; // Zero wait states
  assign pready_o  = access;
  assign pslverr_o = access && !mapped;
  assign lane_en_o = ctrl_q;

  always_comb
  begin
    mapped   = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      ADDR_CTRL:      prdata_o[NUM_LANES-1:0] = ctrl_q;
      ADDR_STATUS:    prdata_o[NUM_LANES-1:0] = lock_i;
      ADDR_PKT_COUNT: prdata_o = pkt_count_q;
      ADDR_LAST_HDR:  prdata_o = last_hdr_q;
      ADDR_ERR_COUNT: prdata_o = err_count_q;
      default:        mapped = 1'b0;
    endcase
  end

  always_ff @(posedge byte_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ctrl_q      <= '0;
      pkt_count_q <= '0;
      err_count_q <= '0;
      last_hdr_q  <= '0;
    end
    else
    begin
      // Only CTRL is writable, other mapped addresses drop the write
      if (access && pwrite_i && (paddr_i == ADDR_CTRL))
        ctrl_q <= pwdata_i[NUM_LANES-1:0];
      if (hdr_valid_i)
      begin
        last_hdr_q <= hdr_i;
        if (pkt_count_q != '1)
          pkt_count_q <= pkt_count_q + 32'd1;
      end
      if (trunc_i && (err_count_q != '1))
        err_count_q <= err_count_q + 32'd1; // Saturates at all ones
    end
  end

endmodule

// ==== logic/dphy_rx_top.sv ====
`timescale 1ns/1ps

module dphy_rx_top #(
  parameter int NUM_LANES = 2
)(
  input  logic                      byte_clk_i,
  input  logic                      arst_n_i,
  input  logic [NUM_LANES-1:0][7:0] lane_raw_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [11:0]               paddr_i,
  input  logic [31:0]               pwdata_i,
  output logic [31:0]               prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  output logic                      pay_valid_o,
  output logic [NUM_LANES-1:0][7:0] pay_data_o,
  output logic [NUM_LANES-1:0]      pay_strb_o
);

  import dphy_rx_pkg::*;

  logic [NUM_LANES-1:0]       lane_en;
  lane_byte_t [NUM_LANES-1:0] lane_byte;
  logic [NUM_LANES-1:0]       lock;
  logic                       mrg_valid;
  logic [NUM_LANES-1:0][7:0]  mrg_data;
  logic                       hdr_valid;
  pkt_hdr_t                   hdr;
  logic                       trunc;

  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_lane
    dphy_hs_lane_rx i_lane_rx (
      .byte_clk_i (byte_clk_i),
      .arst_n_i   (arst_n_i),
      .enable_i   (lane_en[g]),
      .raw_i      (lane_raw_i[g]),
      .byte_o     (lane_byte[g]),
      .lock_o     (lock[g])
    );
  end

  dphy_lane_merge #(.NUM_LANES(NUM_LANES)) i_lane_merge (
    .byte_clk_i (byte_clk_i),
    .arst_n_i   (arst_n_i),
    .lanes_i    (lane_byte),
    .lane_en_i  (lane_en),
    .valid_o    (mrg_valid),
    .data_o     (mrg_data)
  );

  csi_pkt_parser #(.NUM_LANES(NUM_LANES)) i_pkt_parser (
    .byte_clk_i  (byte_clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (mrg_valid),
    .data_i      (mrg_data),
    .hdr_valid_o (hdr_valid),
    .hdr_o       (hdr),
    .pay_valid_o (pay_valid_o),
    .pay_data_o  (pay_data_o),
    .pay_strb_o  (pay_strb_o),
    .trunc_o     (trunc)
  );

  dphy_rx_regs #(.NUM_LANES(NUM_LANES)) i_regs (
    .byte_clk_i  (byte_clk_i),
    .arst_n_i    (arst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .lock_i      (lock),
    .hdr_valid_i (hdr_valid),
    .hdr_i       (hdr),
    .trunc_i     (trunc),
    .lane_en_o   (lane_en)
  );

endmodule

// ==== bench/dphy_rx_assert.sv ====
`timescale 1ns/1ps

module dphy_rx_assert #(
  parameter int NUM_LANES = 2
)(
  input logic                 byte_clk_i,
  input logic                 arst_n_i,
  input logic                 pay_valid_i,
  input logic [NUM_LANES-1:0] pay_strb_i,
  input logic                 psel_i,
  input logic                 pready_i,
  input logic [NUM_LANES-1:0] lock_i,
  input logic [NUM_LANES-1:0] lane_en_i
);

  a_strb_idle : assert property (@(posedge byte_clk_i) disable iff (!arst_n_i)
    !pay_valid_i |-> (pay_strb_i == '0))
    else $error("Payload strobes are set while pay_valid is low");

  // pready belongs to the access phase, which follows a setup cycle with psel high
  a_pready_sel : assert property (@(posedge byte_clk_i) disable iff (!arst_n_i)
    pready_i |-> (psel_i && $past(psel_i)))
    else $error("pready is high outside an APB access phase");

  // A lane lets go of lock one cycle after its enable falls
  a_lock_en : assert property (@(posedge byte_clk_i) disable iff (!arst_n_i)
    (lock_i & ~$past(lane_en_i)) == '0)
    else $error("A lane holds lock while its enable is low");

endmodule

bind dphy_rx_top dphy_rx_assert #(.NUM_LANES(NUM_LANES)) i_dphy_rx_assert (
  .byte_clk_i  (byte_clk_i),
  .arst_n_i    (arst_n_i),
  .pay_valid_i (pay_valid_o),
  .pay_strb_i  (pay_strb_o),
  .psel_i      (psel_i),
  .pready_i    (pready_o),
  .lock_i      (lock),
  .lane_en_i   (lane_en)
);

// ==== bench/dphy_rx_tb.sv ====
`timescale 1ns/1ps

module dphy_rx_tb;

  import dphy_rx_pkg::*;

  localparam int LANES = 2;

  logic                  byte_clk;
  logic                  arst_n;
  logic [LANES-1:0][7:0] lane_raw;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [11:0]           paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  pay_valid;
  logic [LANES-1:0][7:0] pay_data;
  logic [LANES-1:0]      pay_strb;

  logic [7:0]       pkt_bytes [0:127]; // Packet as sent, header first
  logic [7:0]       lane_bytes [LANES][0:127];
  int               lane_len;
  logic [7:0]       rx_q [$];
  logic [LANES-1:0] last_strb;
  int               pay_words;
  int               value_errors;
  int               timeouts;
  logic [31:0]      rd;
  logic             err;

  dphy_rx_top #(.NUM_LANES(LANES)) i_dphy_rx_top (
    .byte_clk_i  (byte_clk),
    .arst_n_i    (arst_n),
    .lane_raw_i  (lane_raw),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .pay_valid_o (pay_valid),
    .pay_data_o  (pay_data),
    .pay_strb_o  (pay_strb)
  );

  initial byte_clk = 1'b0;
  always #20 byte_clk = ~byte_clk;

  // Payload is sampled mid-cycle where it is stable
  always @(negedge byte_clk)
  begin
    if (arst_n && pay_valid)
    begin
      pay_words++;
      last_strb = pay_strb;
      for (int k = 0; k < LANES; k++)
        if (pay_strb[k])
          rx_q.push_back(pay_data[k]);
    end
  end

  task report_mismatch(input string test, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s: expected %h, actual %h", test, exp, act);
    value_errors++;
  endtask

  task apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                  output logic [31:0] rdata, output logic slverr);
    int cycles;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge byte_clk);
    #2 penable = 1'b1;
    @(negedge byte_clk);
    cycles = 0;
    while (!pready && cycles < 16)
    begin
      @(negedge byte_clk);
      cycles++;
    end
    if (!pready)
    begin
      $display("APB transfer to address %h timed out waiting for pready", addr);
      timeouts++;
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge byte_clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task poll_reg(input string test, input logic [11:0] addr, input logic [31:0] exp);
    int tries;
    tries = 0;
    apb_access(1'b0, addr, '0, rd, err);
    while (rd !== exp && tries < 40)
    begin
      apb_access(1'b0, addr, '0, rd, err);
      tries++;
    end
    if (rd !== exp)
    begin
      $display("%s: timed out waiting for register %h to read %h", test, addr, exp);
      timeouts++;
    end
  endtask

  task build_packet(input logic [7:0] id, input logic [15:0] wc, input logic [7:0] ecc);
    pkt_bytes[0] = id;
    pkt_bytes[1] = wc[7:0]; // Word count goes out LSB first
    pkt_bytes[2] = wc[15:8];
    pkt_bytes[3] = ecc;
    if (id >= 8'h10)
    begin
      for (int i = 0; i < wc; i++)
        pkt_bytes[4 + i] = 8'($urandom);
      pkt_bytes[4 + wc] = 8'hA5;
      pkt_bytes[5 + wc] = 8'h5A;
    end
  endtask

  function automatic logic stream_bit(input int lane, input int pos, input int offset);
    int q;
    if (pos < offset)
      return 1'b0;
    q = pos - offset;
    if (q / 8 >= lane_len)
      return 1'b0;
    return lane_bytes[lane][q / 8][q % 8];
  endfunction

  // Round robin over the lanes, each lane led by two zero bytes and the sync byte
  task send_burst(input int offset, input int nbytes);
    int per_lane;
    int words;
    per_lane = (nbytes + LANES - 1) / LANES;
    lane_len = 3 + per_lane + 2;
    for (int l = 0; l < LANES; l++)
      for (int i = 0; i < lane_len; i++)
        lane_bytes[l][i] = (i == 2) ? SYNC_BYTE : 8'h00;
    for (int i = 0; i < nbytes; i++)
      lane_bytes[i % LANES][3 + i / LANES] = pkt_bytes[i];
    words = (offset + 8 * lane_len + 7) / 8;
    for (int w = 0; w < words; w++)
    begin
      for (int l = 0; l < LANES; l++)
        for (int b = 0; b < 8; b++)
          lane_raw[l][b] = stream_bit(l, 8 * w + b, offset);
      @(posedge byte_clk);
      #2;
    end
    lane_raw = '0;
  endtask

  task long_packet(input string test, input logic [7:0] id, input logic [15:0] wc,
                   input int offset);
    logic [31:0]      count0;
    logic [LANES-1:0] exp_strb;
    int               cycles;
    rx_q.delete();
    apb_access(1'b0, ADDR_PKT_COUNT, '0, count0, err);
    build_packet(id, wc, 8'h3C);
    apb_access(1'b1, ADDR_CTRL, 32'h3, rd, err);
    send_burst(offset, 4 + wc + 2);
    cycles = 0;
    while (rx_q.size() < wc && cycles < 100)
    begin
      @(posedge byte_clk);
      #2;
      cycles++;
    end
    if (rx_q.size() < wc)
    begin
      $display("%s: timed out waiting for %0d payload bytes", test, wc);
      timeouts++;
    end
    repeat (8) @(posedge byte_clk); // Room for stray CRC strobes to show up
    #2;
    apb_access(1'b1, ADDR_CTRL, 32'h0, rd, err);
    if (rx_q.size() != wc)
      report_mismatch(test, wc, rx_q.size());
    else
      for (int i = 0; i < wc; i++)
        if (rx_q[i] !== pkt_bytes[4 + i])
          report_mismatch(test, pkt_bytes[4 + i], rx_q[i]);
    exp_strb = '1;
    if (wc % LANES != 0)
      exp_strb = (1 << (wc % LANES)) - 1;
    if (last_strb !== exp_strb)
      report_mismatch(test, exp_strb, last_strb);
    apb_access(1'b0, ADDR_PKT_COUNT, '0, rd, err);
    if (rd !== count0 + 1)
      report_mismatch(test, count0 + 1, rd);
    apb_access(1'b0, ADDR_LAST_HDR, '0, rd, err);
    if (rd !== {id, wc, 8'h3C})
      report_mismatch(test, {id, wc, 8'h3C}, rd);
  endtask

  task register_access;
    for (int a = 0; a <= 16; a += 4)
    begin
      apb_access(1'b0, 12'(a), '0, rd, err);
      if (rd !== 32'h0 || err !== 1'b0)
        report_mismatch("register_access", 32'h0, rd | {31'h0, err});
    end
    apb_access(1'b1, ADDR_CTRL, 32'h3, rd, err);
    apb_access(1'b0, ADDR_CTRL, '0, rd, err);
    if (rd !== 32'h3)
      report_mismatch("register_access", 32'h3, rd);
    apb_access(1'b1, ADDR_CTRL, 32'h0, rd, err);
    apb_access(1'b0, 12'h020, '0, rd, err);
    if (err !== 1'b1)
      report_mismatch("register_access", 32'h1, err);
    apb_access(1'b1, ADDR_STATUS, 32'hFFFF_FFFF, rd, err);
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    if (rd !== 32'h0)
      report_mismatch("register_access", 32'h0, rd);
  endtask

  task lock_all_offsets;
    for (int off = 0; off < 8; off++)
    begin
      apb_access(1'b1, ADDR_CTRL, 32'h3, rd, err);
      send_burst(off, 0);
      poll_reg("lock_all_offsets", ADDR_STATUS, 32'h3);
      apb_access(1'b1, ADDR_CTRL, 32'h0, rd, err);
      apb_access(1'b0, ADDR_STATUS, '0, rd, err);
      if (rd !== 32'h0)
        report_mismatch("lock_all_offsets", 32'h0, rd);
    end
  endtask

  task short_packet;
    logic [31:0] count0;
    int          words0;
    apb_access(1'b0, ADDR_PKT_COUNT, '0, count0, err);
    words0 = pay_words;
    build_packet(8'h01, 16'h0005, 8'h2C);
    apb_access(1'b1, ADDR_CTRL, 32'h3, rd, err);
    send_burst(5, 4);
    poll_reg("short_packet", ADDR_PKT_COUNT, count0 + 1);
    repeat (4) @(posedge byte_clk);
    #2;
    apb_access(1'b1, ADDR_CTRL, 32'h0, rd, err);
    apb_access(1'b0, ADDR_LAST_HDR, '0, rd, err);
    if (rd !== 32'h0100_052C)
      report_mismatch("short_packet", 32'h0100_052C, rd);
    if (pay_words != words0)
      report_mismatch("short_packet", words0, pay_words);
  endtask

  task truncation_recovery;
    logic [31:0] err0;
    apb_access(1'b0, ADDR_ERR_COUNT, '0, err0, err);
    build_packet(8'h2B, 16'd40, 8'h15);
    apb_access(1'b1, ADDR_CTRL, 32'h3, rd, err);
    send_burst(2, 14); // Header and ten payload bytes of forty
    apb_access(1'b1, ADDR_CTRL, 32'h0, rd, err);
    poll_reg("truncation_recovery", ADDR_ERR_COUNT, err0 + 1);
    long_packet("truncation_recovery", 8'h2A, 16'd9, 6);
    apb_access(1'b0, ADDR_ERR_COUNT, '0, rd, err);
    if (rd !== err0 + 1)
      report_mismatch("truncation_recovery", err0 + 1, rd);
  endtask

  initial
  begin
    void'($urandom(32'hdf02_1d57));
    value_errors = 0;
    timeouts     = 0;
    pay_words    = 0;
    last_strb    = '0;
    arst_n       = 1'b0;
    lane_raw     = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    repeat (4) @(posedge byte_clk);
    #2 arst_n = 1'b1;
    register_access();
    lock_all_offsets();
    long_packet("long_packet", 8'h2A, 16'd23, 3);
    short_packet();
    truncation_recovery();
    $display("Error counts: %0d value mismatches, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== dphy_rx.f ====
logic/dphy_rx_pkg.sv
logic/dphy_hs_lane_rx.sv
logic/dphy_lane_merge.sv
logic/csi_pkt_parser.sv
logic/dphy_rx_regs.sv
logic/dphy_rx_top.sv
bench/dphy_rx_assert.sv
bench/dphy_rx_tb.sv

// ==== Bender.yml ====
package:
  name: dphy_rx

sources:
  - target: rtl
    files:
      - logic/dphy_rx_pkg.sv
      - logic/dphy_hs_lane_rx.sv
      - logic/dphy_lane_merge.sv
      - logic/csi_pkt_parser.sv
      - logic/dphy_rx_regs.sv
      - logic/dphy_rx_top.sv

  - target: test
    files:
      - bench/dphy_rx_assert.sv
      - bench/dphy_rx_tb.sv
